//--- filelist.f
rtl/io_pkg.sv
rtl/sync_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/perf_counters.sv
rtl/mmio_port.sv
rtl/io_subsystem.sv
sim/io_subsystem_assert.sv
sim/io_subsystem_tb.sv

//--- rtl/io_pkg.sv
package io_pkg;

    // Data widths
    typedef logic [31:0] word_t;     // Processor data word
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [7:0]  byte_t;     // UART payload
    typedef logic [5:0]  led_t;      // LED bank

    // Baud generation, sized for fast simulation
    localparam int CLOCK_FREQ   = 25_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;   // Clocks within one bit

    localparam baud_cnt_t BIT_END = baud_cnt_t'(CLKS_PER_BIT - 1);     // Last clock of a bit
    localparam baud_cnt_t BIT_MID = baud_cnt_t'(CLKS_PER_BIT / 2 - 1); // Half a bit

    localparam int UART_FIFO_DEPTH = 8;

    // I/O memory map
    localparam addr_t ADDR_UART_CTRL = 32'h8000_0000;   // Status, read only
    localparam addr_t ADDR_UART_RX   = 32'h8000_0004;   // Read pops receive FIFO
    localparam addr_t ADDR_UART_TX   = 32'h8000_0008;   // Write pushes transmit FIFO
    localparam addr_t ADDR_CYCLE_CNT = 32'h8000_0010;
    localparam addr_t ADDR_INST_CNT  = 32'h8000_0014;
    localparam addr_t ADDR_CNT_CLEAR = 32'h8000_0018;   // Any write clears both counters
    localparam addr_t ADDR_LEDS      = 32'h8000_0030;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

//--- rtl/io_subsystem.sv
`timescale 1ns/1ps

module io_subsystem
    import io_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  logic  inst_retired,
    output logic  rsp_valid,
    output word_t rsp_rdata,
    input  logic  serial_in,
    output logic  serial_out,
    output led_t  leds
);
    // Transmit path
    logic  tx_push;
    byte_t tx_data;
    byte_t tx_head;
    logic  tx_full;
    logic  tx_empty;
    logic  tx_ready;
    wire   tx_valid = !tx_empty;
    wire   tx_pop   = tx_valid && tx_ready;    // Handshake with the transmitter

    // Receive path
    byte_t rx_byte;
    logic  rx_valid;
    logic  rx_full;
    logic  rx_empty;
    logic  rx_pop;
    byte_t rx_head;
    wire   rx_ready = !rx_full;
    wire   rx_push  = rx_valid && rx_ready;

    // Counters
    logic  cnt_clear;
    word_t cycle_count;
    word_t inst_count;

    mmio_port mmio_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .tx_not_full  (!tx_full),      // From tx_fifo
        .rx_not_empty (!rx_empty),     // From rx_fifo
        .rx_head      (rx_head),       // From rx_fifo
        .cycle_count  (cycle_count),   // From perf_counters
        .inst_count   (inst_count),    // From perf_counters
        .tx_push      (tx_push),       // To tx_fifo
        .tx_data      (tx_data),       // To tx_fifo
        .rx_pop       (rx_pop),        // To rx_fifo
        .cnt_clear    (cnt_clear),     // To perf_counters
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .leds         (leds)
    );

    sync_fifo #(
        .DEPTH (UART_FIFO_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .head      (tx_head),          // To uart_tx
        .full      (tx_full),
        .empty     (tx_empty)
    );

    uart_tx uart_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data    (tx_head),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx uart_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .serial_in (serial_in),
        .rx_ready  (rx_ready),
        .rx_data   (rx_byte),          // To rx_fifo
        .rx_valid  (rx_valid)
    );

    sync_fifo #(
        .DEPTH (UART_FIFO_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_byte),
        .pop       (rx_pop),
        .head      (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    perf_counters perf_counters (
        .clk          (clk),
        .rst_n        (rst_n),
        .cnt_clear    (cnt_clear),
        .inst_retired (inst_retired),
        .cycle_count  (cycle_count),
        .inst_count   (inst_count)
    );

endmodule

//--- rtl/mmio_port.sv
`timescale 1ns/1ps

module mmio_port
    import io_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  logic  tx_not_full,
    input  logic  rx_not_empty,
    input  byte_t rx_head,
    input  word_t cycle_count,
    input  word_t inst_count,
    output logic  tx_push,
    output byte_t tx_data,
    output logic  rx_pop,
    output logic  cnt_clear,
    output logic  rsp_valid,
    output word_t rsp_rdata,
    output led_t  leds
);
    logic  store;
    logic  load;
    word_t read_data;

    assign store = req_valid && req_write;
    assign load  = req_valid && !req_write;

    // Store side strobes, all acting at the end of the request cycle
    assign tx_push   = store && (req_addr == ADDR_UART_TX) && tx_not_full;  // Full drops it
    assign tx_data   = req_wdata[7:0];
    assign cnt_clear = store && (req_addr == ADDR_CNT_CLEAR);
    assign rx_pop    = load && (req_addr == ADDR_UART_RX) && rx_not_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (store && req_addr == ADDR_LEDS) begin
            leds <= req_wdata[5:0];
        end
    end

    // Load data as seen in the request cycle
    always_comb begin
        case (req_addr)
            ADDR_UART_CTRL: read_data = {30'b0, rx_not_empty, tx_not_full};
            ADDR_UART_RX:   read_data = {24'b0, rx_head};
            ADDR_CYCLE_CNT: read_data = cycle_count;
            ADDR_INST_CNT:  read_data = inst_count;
            default:        read_data = '0;    // Unmapped and write-only
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= load;  // Answer one cycle after the address
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp_rdata <= read_data;
        end
    end

endmodule

//--- rtl/perf_counters.sv
`timescale 1ns/1ps

module perf_counters
    import io_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cnt_clear,
    input  logic  inst_retired,
    output word_t cycle_count,
    output word_t inst_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
            inst_count  <= '0;
        end else if (cnt_clear) begin
            cycle_count <= '0;      // Clear wins over counting
            inst_count  <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (inst_retired) begin
                inst_count <= inst_count + 1'b1;
            end
        end
    end

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
    import io_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t head,
    output logic  full,
    output logic  empty
);
    localparam int PTR_W = $clog2(DEPTH);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;    // One extra bit to tell full from empty

    // Callers gate push with full and pop with empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps for power-of-two depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head  = mem[rd_ptr];     // Oldest entry, valid when not empty
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign empty = (count == '0);

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import io_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  serial_in,
    input  logic  rx_ready,
    output byte_t rx_data,
    output logic  rx_valid
);
    logic [1:0] rx_sync;    // Two-flop synchroniser
    logic       rx_bit;
    rx_state_t  state;
    baud_cnt_t  bit_timer;
    logic [2:0] bit_idx;
    byte_t      shift_reg;
    logic       start_seen;
    logic       sample;

    assign rx_bit     = rx_sync[1];
    assign start_seen = (state == RX_IDLE) && !rx_bit;
    // Start bit counts half a bit, the rest count whole bits, so samples land mid-bit
    assign sample     = (state == RX_START) ? (bit_timer == BIT_MID) : (bit_timer == BIT_END);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync   <= 2'b11;     // Line idles high
            state     <= RX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], serial_in};
            if (state == RX_IDLE || sample) begin
                bit_timer <= '0;
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (!rx_bit) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        state   <= rx_bit ? RX_IDLE : RX_DATA;  // Glitch check
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
            if (state == RX_STOP && sample && rx_bit) begin
                rx_valid <= 1'b1;   // Good stop bit
            end else if ((rx_valid && rx_ready) || start_seen) begin
                rx_valid <= 1'b0;   // Taken, or lost to the next frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample) begin
            shift_reg <= {rx_bit, shift_reg[7:1]};  // LSB arrives first
        end
    end

    assign rx_data = shift_reg;

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import io_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    output logic  serial_out
);
    tx_state_t  state;
    baud_cnt_t  bit_timer;
    logic [2:0] bit_idx;
    byte_t      shift_reg;
    logic       bit_done;

    assign bit_done = (bit_timer == BIT_END);
    assign tx_ready = (state == TX_IDLE);   // Takes a byte only between frames

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            if (state == TX_IDLE || bit_done) begin
                bit_timer <= '0;
            end else begin
                bit_timer <= bit_timer + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (tx_valid) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;   // All eight bits sent
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk) begin
        if (tx_ready && tx_valid) begin
            shift_reg <= tx_data;
        end else if (state == TX_DATA && bit_done) begin
            shift_reg <= {1'b1, shift_reg[7:1]};
        end
    end

    always_comb begin
        case (state)
            TX_START: serial_out = 1'b0;
            TX_DATA:  serial_out = shift_reg[0];
            default:  serial_out = 1'b1;    // Idle and stop hold the line high
        endcase
    end

endmodule

//--- sim/io_subsystem_assert.sv
`timescale 1ns/1ps

module io_subsystem_assert
    import io_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  req_valid,
    input logic  req_write,
    input addr_t req_addr,
    input logic  rsp_valid,
    input led_t  leds,
    input logic  serial_out,
    input logic  tx_push,
    input logic  tx_pop
);
    int unsigned fail_count = 0;
    int          tx_level;      // Transmit FIFO occupancy rebuilt from its strobes
    logic        load;
    logic        led_store;

    assign load      = req_valid && !req_write;
    assign led_store = req_valid && req_write && (req_addr == ADDR_LEDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_level <= 0;
        end else begin
            tx_level <= tx_level + int'(tx_push) - int'(tx_pop);
        end
    end

    rsp_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> rsp_valid
    ) else begin
        $error("load was not answered in the next cycle");
        fail_count++;
    end

    rsp_needs_load: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(load)
    ) else begin
        $error("response without a load one cycle earlier");
        fail_count++;
    end

    // LEDs move only as a result of their own store
    leds_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(leds) |-> $past(led_store)
    ) else begin
        $error("leds changed without a store to the LED register");
        fail_count++;
    end

    tx_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        tx_push |-> (tx_level < UART_FIFO_DEPTH)
    ) else begin
        $error("push into a full transmit FIFO");
        fail_count++;
    end

    tx_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        tx_pop |-> (tx_level > 0)
    ) else begin
        $error("pop from an empty transmit FIFO");
        fail_count++;
    end

    line_idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> serial_out
    ) else begin
        $error("serial line not idle during reset");
        fail_count++;
    end

endmodule

bind io_subsystem io_subsystem_assert assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .rsp_valid  (rsp_valid),
    .leds       (leds),
    .serial_out (serial_out),
    .tx_push    (tx_push),
    .tx_pop     (tx_pop)
);

//--- sim/io_subsystem_tb.sv
`timescale 1ns/1ps

module io_subsystem_tb
    import io_pkg::*;
;
    localparam int    CLK_PERIOD   = 40;    // ns
    localparam int    RESET_CYCLES = 16;
    localparam int    LOOP_BYTES   = 4;
    localparam int    BURST_BYTES  = 12;    // More than the FIFO holds
    localparam int    BYTE_CYCLES  = 10 * CLKS_PER_BIT;
    localparam int    POLL_CYCLES  = 1220;  // Loads, stores and status polling
    localparam int    WATCHDOG_NS  =
        2 * ((LOOP_BYTES + BURST_BYTES) * BYTE_CYCLES + POLL_CYCLES) * CLK_PERIOD;
    localparam int    COUNT_GAP    = 37;
    localparam addr_t ADDR_UNMAPPED = 32'h8000_0040;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    logic  inst_retired;
    logic  rsp_valid;
    word_t rsp_rdata;
    wire   serial_line;     // Loopback from serial_out to serial_in
    led_t  leds;

    integer seed = 32'hdb26_efa0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     inst_pulses = 0;
    int     pulses_at_load = 0;
    byte_t  tx_bytes [LOOP_BYTES + BURST_BYTES];
    byte_t  expected_q [$];

    io_subsystem dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .inst_retired (inst_retired),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .serial_in    (serial_line),
        .serial_out   (serial_line),
        .leds         (leds)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        inst_retired = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            inst_retired = 1'($random(seed));
        end
    end

    // Reference count where a clear in the same cycle wins over a pulse
    always @(posedge clk) begin
        if (req_valid && req_write && req_addr == ADDR_CNT_CLEAR) begin
            inst_pulses = 0;
        end else if (inst_retired) begin
            inst_pulses = inst_pulses + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int failure_total();
        return errors + int'(dut_i.assert_i.fail_count);
    endfunction

    task automatic store(input addr_t addr, input word_t data);
        @(negedge clk);
        req_valid = 1'b1;
        req_write = 1'b1;
        req_addr  = addr;
        req_wdata = data;
        @(negedge clk);
        req_valid = 1'b0;
        req_write = 1'b0;
    endtask

    task automatic load(input addr_t addr, output word_t data);
        @(negedge clk);
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr  = addr;
        pulses_at_load = inst_pulses;   // Pulses before the request cycle
        @(negedge clk);
        req_valid = 1'b0;
        data = rsp_rdata;               // Middle of the response cycle
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (failure_total() > mark) begin
            tests_failed++;
            $display("test %s: fail", name);
        end else begin
            $display("test %s: pass", name);
        end
    endtask

    // Polls status bit 1 before each receive read
    task automatic receive_expected();
        word_t status;
        word_t rdata;
        byte_t exp;
        while (expected_q.size() > 0) begin
            exp    = expected_q.pop_front();
            status = '0;
            while (!status[1]) begin
                load(ADDR_UART_CTRL, status);
            end
            load(ADDR_UART_RX, rdata);
            check_value("received byte", rdata, {24'b0, exp});
        end
        load(ADDR_UART_CTRL, status);
        check_value("receive valid after last byte", {31'b0, status[1]}, '0);
    endtask

    initial begin
        word_t rdata;
        word_t first;
        word_t second;
        word_t status;
        int    mark;
        int    sent;
        bit    saw_full;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        foreach (tx_bytes[i]) begin
            tx_bytes[i] = byte_t'($random(seed));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = failure_total();
        check_value("leds after reset", word_t'(leds), '0);
        check_value("serial_out after reset", {31'b0, serial_line}, 32'd1);
        load(ADDR_UART_CTRL, rdata);
        check_value("status after reset", rdata, 32'd1);  // Transmit ready only
        end_test("reset_state", mark);

        mark = failure_total();
        store(ADDR_LEDS, 32'h0000_05a5);
        check_value("leds", word_t'(leds), 32'h25);     // Bits 5:0 of 0x5a5
        store(ADDR_LEDS, 32'hffff_ffc3);
        check_value("leds", word_t'(leds), 32'h03);
        store(ADDR_UNMAPPED, 32'h0000_003f);
        check_value("leds after unmapped store", word_t'(leds), 32'h03);
        load(ADDR_UNMAPPED, rdata);
        check_value("unmapped load", rdata, '0);
        end_test("led_register", mark);

        mark = failure_total();
        for (int i = 0; i < LOOP_BYTES; i++) begin
            store(ADDR_UART_TX, {24'b0, tx_bytes[i]});
            expected_q.push_back(tx_bytes[i]);
        end
        receive_expected();
        end_test("uart_loopback", mark);

        mark     = failure_total();
        sent     = 0;
        saw_full = 1'b0;
        while (sent < BURST_BYTES) begin
            load(ADDR_UART_CTRL, status);
            if (status[0]) begin
                store(ADDR_UART_TX, {24'b0, tx_bytes[LOOP_BYTES + sent]});
                expected_q.push_back(tx_bytes[LOOP_BYTES + sent]);
                sent++;
            end else begin
                saw_full = 1'b1;
            end
        end
        if (!saw_full) begin
            $display("transmit FIFO never reported full during the burst");
            errors++;
        end
        receive_expected();
        end_test("back_pressure", mark);

        mark = failure_total();
        store(ADDR_CNT_CLEAR, 32'hdead_beef);
        load(ADDR_CYCLE_CNT, first);
        check_value("cycle count after clear", first, 32'd1);   // Two cycles after the clear
        repeat (COUNT_GAP - 2) @(negedge clk);
        load(ADDR_CYCLE_CNT, second);
        check_value("cycle count difference", second - first, word_t'(COUNT_GAP));
        repeat (5) @(negedge clk);
        load(ADDR_INST_CNT, rdata);
        check_value("retired instructions", rdata, word_t'(pulses_at_load));
        end_test("counters", mark);

        $display("tests run %0d, passed %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors,
                 dut_i.assert_i.fail_count);
        if (failure_total() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
